// ==== logic/memq_pkg.sv ====
// memq shared sizing and types
// one package for the queue, hazard checker, arbiter and bench

package memq_pkg;

    // request address width
    localparam int ADDR_W = 8;

    // storage slots per queue, one slot always stays free
    // so usable capacity is DEPTH-1
    localparam int DEPTH = 4;

    // head/tail pointer width, wraps naturally at DEPTH
    localparam int PTR_W = $clog2(DEPTH);

    // usable entries per queue
    localparam int CAPACITY = DEPTH - 1;

    // per-cycle arbiter decision
    typedef enum logic [1:0] {
        ISSUE_NONE  = 2'd0,     // nothing goes out this cycle
        ISSUE_READ  = 2'd1,     // read queue head goes out
        ISSUE_WRITE = 2'd2      // write queue head goes out
    } issue_kind_e;

endpackage

// ==== logic/req_queue_if.sv ====
// request queue bundle: push side, pop side, status and visible slots
`timescale 1ns/1ps

interface req_queue_if;

    // push side, driven by top level routing
    logic                        push;
    logic [memq_pkg::ADDR_W-1:0] push_addr;

    // pop side, driven by the arbiter
    logic                        pop;

    // queue state, driven by req_fifo
    logic [memq_pkg::ADDR_W-1:0] head_addr;     // oldest entry
    logic [memq_pkg::PTR_W-1:0]  head_ptr;
    logic [memq_pkg::PTR_W-1:0]  tail_ptr;      // next free slot
    logic                        empty;
    logic                        full;
    logic [memq_pkg::ADDR_W-1:0] entries [memq_pkg::DEPTH];  // raw slots

    // the queue itself
    modport store (
        input  push, push_addr, pop,
        output head_addr, head_ptr, tail_ptr, empty, full, entries
    );

    // consumer that pops the head
    modport issue (
        output pop,
        input  head_addr, empty
    );

    // read-only view for address search
    modport snoop (
        input head_addr, head_ptr, tail_ptr, empty, entries
    );

endinterface

// ==== logic/req_fifo.sv ====
// request address queue, circular buffer with head/tail pointers
// exposes all slots so the occupied range can be searched
`timescale 1ns/1ps

module req_fifo (
    input logic   clkin,
    input logic   rst,
    req_queue_if.store q
);

    logic [memq_pkg::ADDR_W-1:0] mem [memq_pkg::DEPTH];  // address slots
    logic [memq_pkg::PTR_W-1:0]  head;                   // next to pop
    logic [memq_pkg::PTR_W-1:0]  tail;                   // next to fill
    logic [memq_pkg::PTR_W-1:0]  tail_inc;               // tail + 1, wrapped
    logic                        do_push;
    logic                        do_pop;

    assign tail_inc = tail + 1'b1;      // truncates to PTR_W, so it wraps

    // one slot stays unused so full and empty differ
    assign q.empty = (head == tail);
    assign q.full  = (tail_inc == head);

    // full drops the request, empty ignores a stray pop
    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    // pointer update, push and pop may happen in the same cycle
    always_ff @(posedge clkin) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (do_push) begin
                tail <= tail_inc;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // slot storage, payload only so no reset
    always_ff @(posedge clkin) begin
        if (do_push) begin
            mem[tail] <= q.push_addr;
        end
    end

    assign q.head_addr = mem[head];     // valid only while not empty
    assign q.head_ptr  = head;
    assign q.tail_ptr  = tail;

    // every slot visible to the hazard search
    for (genvar i = 0; i < memq_pkg::DEPTH; i++) begin : g_entries
        assign q.entries[i] = mem[i];
    end

endmodule

// ==== logic/raw_hazard_check.sv ====
// read-after-write hazard search
// flags a read head whose address is still waiting in the write queue
`timescale 1ns/1ps

module raw_hazard_check (
    req_queue_if.snoop rdq,
    req_queue_if.snoop wrq,
    output logic       read_blocked
);

    logic [memq_pkg::DEPTH-1:0] occupied;   // write slot holds a live entry
    logic [memq_pkg::DEPTH-1:0] hit;        // live entry matches read head

    always_comb begin
        logic [memq_pkg::PTR_W-1:0] idx;
        logic                       no_wrap;

        no_wrap = (wrq.head_ptr <= wrq.tail_ptr);   // head==tail gives empty range
        for (int i = 0; i < memq_pkg::DEPTH; i++) begin
            idx = memq_pkg::PTR_W'(i);
            if (no_wrap) begin
                // live range is head..tail-1
                occupied[i] = (idx >= wrq.head_ptr) && (idx < wrq.tail_ptr);
            end else begin
                // range wraps past the last slot
                occupied[i] = (idx >= wrq.head_ptr) || (idx < wrq.tail_ptr);
            end
            hit[i] = occupied[i] && (wrq.entries[i] == rdq.head_addr);
        end
    end

    // head_addr of an empty read queue is stale, so mask it
    assign read_blocked = !rdq.empty && (|hit);

endmodule

// ==== logic/issue_arbiter.sv ====
// issue arbiter: registers grant, picks read, write or nothing per cycle
// pops the chosen queue and drives a one-cycle issue on the outputs
`timescale 1ns/1ps

module issue_arbiter (
    input  logic                        clkin,
    input  logic                        rst,
    input  logic                        bus_gnt,
    input  logic                        read_blocked,
    req_queue_if.issue                  rdq,
    req_queue_if.issue                  wrq,
    output logic [memq_pkg::ADDR_W-1:0] out_addr,
    output logic                        out_is_read,
    output logic                        valid_out
);

    logic                  gnt_q;       // grant delayed one cycle
    memq_pkg::issue_kind_e issue_kind;  // this cycle's decision

    always_ff @(posedge clkin) begin
        if (rst) begin
            gnt_q <= 1'b0;
        end else begin
            gnt_q <= bus_gnt;
        end
    end

    // reads go first unless an older write to the same address waits
    always_comb begin
        issue_kind = memq_pkg::ISSUE_NONE;
        if (gnt_q) begin
            if (!rdq.empty && !read_blocked) begin
                issue_kind = memq_pkg::ISSUE_READ;
            end else if (!wrq.empty) begin
                issue_kind = memq_pkg::ISSUE_WRITE;   // also drains blocking writes
            end
        end
    end

    assign rdq.pop = (issue_kind == memq_pkg::ISSUE_READ);
    assign wrq.pop = (issue_kind == memq_pkg::ISSUE_WRITE);

    // output register, valid_out pulses once per issue
    always_ff @(posedge clkin) begin
        if (rst) begin
            out_addr    <= '0;
            out_is_read <= 1'b0;
            valid_out   <= 1'b0;
        end else begin
            case (issue_kind)
                memq_pkg::ISSUE_READ: begin
                    out_addr    <= rdq.head_addr;
                    out_is_read <= 1'b1;
                    valid_out   <= 1'b1;
                end
                memq_pkg::ISSUE_WRITE: begin
                    out_addr    <= wrq.head_addr;
                    out_is_read <= 1'b0;
                    valid_out   <= 1'b1;
                end
                default: begin
                    valid_out   <= 1'b0;    // addr and kind hold last issue
                end
            endcase
        end
    end

endmodule

// ==== logic/memq_top.sv ====
// memq top: routes requests into read/write queues
// hazard checker and arbiter issue them onto the memory bus
`timescale 1ns/1ps

module memq_top (
    input  logic                        clkin,
    input  logic                        rst,
    input  logic                        valid_in,
    input  logic                        is_read,
    input  logic [memq_pkg::ADDR_W-1:0] in_addr,
    input  logic                        bus_gnt,
    output logic [memq_pkg::ADDR_W-1:0] out_addr,
    output logic                        out_is_read,
    output logic                        valid_out,
    output logic                        read_full,
    output logic                        write_full,
    output logic [memq_pkg::ADDR_W-1:0] read_head_addr
);

    req_queue_if rdq ();    // read request queue
    req_queue_if wrq ();    // write request queue

    logic read_blocked;     // read head waits on an older write

    // request routing, a full queue drops the request
    assign rdq.push      = valid_in && is_read && !rdq.full;
    assign rdq.push_addr = in_addr;
    assign wrq.push      = valid_in && !is_read && !wrq.full;
    assign wrq.push_addr = in_addr;

    req_fifo u_rd_fifo (
        .clkin (clkin),
        .rst   (rst),
        .q     (rdq)
    );

    req_fifo u_wr_fifo (
        .clkin (clkin),
        .rst   (rst),
        .q     (wrq)
    );

    raw_hazard_check u_hazard (
        .rdq          (rdq),
        .wrq          (wrq),
        .read_blocked (read_blocked)
    );

    issue_arbiter u_arbiter (
        .clkin        (clkin),
        .rst          (rst),
        .bus_gnt      (bus_gnt),
        .read_blocked (read_blocked),
        .rdq          (rdq),
        .wrq          (wrq),
        .out_addr     (out_addr),
        .out_is_read  (out_is_read),
        .valid_out    (valid_out)
    );

    // status for the requester
    assign read_full      = rdq.full;
    assign write_full     = wrq.full;
    assign read_head_addr = rdq.head_addr;

endmodule

// ==== bench/memq_asserts.sv ====
// memq protocol assertions, bound into the top level
// covers grant timing, hazard blocking, queue push rules and reset
`timescale 1ns/1ps

module memq_asserts (
    input logic                         clkin,
    input logic                         rst,
    input logic                         gnt_q,
    input logic                         read_blocked,
    input logic                         valid_out,
    input logic                         out_is_read,
    input logic                         rd_full,
    input logic [memq_pkg::PTR_W-1:0]   rd_tail,
    input logic                         wr_full,
    input logic [memq_pkg::PTR_W-1:0]   wr_tail
);

    int failures = 0;   // count of failed assertions

    // an issue needs the registered grant on the edge that made it
    a_gnt_before_issue: assert property (
        @(posedge clkin) disable iff (rst) !$past(gnt_q) |-> !valid_out
    ) else begin
        failures++;
        $error("valid_out after an edge with gnt_q low");
    end

    // a read on the bus was not blocked on the edge that issued it
    a_blocked_read: assert property (
        @(posedge clkin) disable iff (rst)
        (valid_out && out_is_read) |-> !$past(read_blocked)
    ) else begin
        failures++;
        $error("read issued while read_blocked");
    end

    // a full queue takes no entry, so its tail stays put
    a_rd_push_full: assert property (
        @(posedge clkin) disable iff (rst) rd_full |=> $stable(rd_tail)
    ) else begin
        failures++;
        $error("push into full read queue");
    end

    a_wr_push_full: assert property (
        @(posedge clkin) disable iff (rst) wr_full |=> $stable(wr_tail)
    ) else begin
        failures++;
        $error("push into full write queue");
    end

    a_reset_quiet: assert property (
        @(posedge clkin) rst |=> !valid_out
    ) else begin
        failures++;
        $error("valid_out high after a reset cycle");
    end

endmodule

// ==== bench/memq_tb.sv ====
// memq testbench: directed and random request mixes against a queue model
// model compares every cycle, each test also checks its own issue order
`timescale 1ns/1ps

module memq_tb;

    localparam int SEED_INIT  = 67042;
    localparam int WAIT_LIMIT = 60;                     // cycles per wait loop
    localparam int CAP        = memq_pkg::CAPACITY;     // usable entries per queue

    logic                        clkin;
    logic                        rst;
    logic                        valid_in;
    logic                        is_read;
    logic [memq_pkg::ADDR_W-1:0] in_addr;
    logic                        bus_gnt;
    logic [memq_pkg::ADDR_W-1:0] out_addr;
    logic                        out_is_read;
    logic                        valid_out;
    logic                        read_full;
    logic                        write_full;
    logic [memq_pkg::ADDR_W-1:0] read_head_addr;

    // reference model, updated on rising edges
    logic [memq_pkg::ADDR_W-1:0] rd_m [$];
    logic [memq_pkg::ADDR_W-1:0] wr_m [$];
    logic                        gnt_m;
    logic                        model_live = 1'b0;   // set once reset is released
    logic                        exp_valid;
    logic                        exp_is_read;
    logic [memq_pkg::ADDR_W-1:0] exp_addr;

    logic [memq_pkg::ADDR_W:0]   got_q [$];   // {is_read, addr} seen by the current test
    int errors       = 0;
    int model_errors = 0;
    int tests_run    = 0;
    int seed;

    memq_top u_dut (
        .clkin          (clkin),
        .rst            (rst),
        .valid_in       (valid_in),
        .is_read        (is_read),
        .in_addr        (in_addr),
        .bus_gnt        (bus_gnt),
        .out_addr       (out_addr),
        .out_is_read    (out_is_read),
        .valid_out      (valid_out),
        .read_full      (read_full),
        .write_full     (write_full),
        .read_head_addr (read_head_addr)
    );

    bind memq_top memq_asserts u_asserts (
        .clkin        (clkin),
        .rst          (rst),
        .gnt_q        (u_arbiter.gnt_q),
        .read_blocked (read_blocked),
        .valid_out    (valid_out),
        .out_is_read  (out_is_read),
        .rd_full      (rdq.full),
        .rd_tail      (rdq.tail_ptr),
        .wr_full      (wrq.full),
        .wr_tail      (wrq.tail_ptr)
    );

    initial begin
        clkin = 1'b0;
        forever #2 clkin = ~clkin;  // 4 ns period
    end

    function automatic int error_total();
        return errors + model_errors + u_dut.u_asserts.failures;
    endfunction

    // true when an older write to this address still waits
    function automatic logic write_pending(input logic [memq_pkg::ADDR_W-1:0] a);
        foreach (wr_m[i]) begin
            if (wr_m[i] == a) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // queue model: decision and full flags come from the state before the edge
    always @(posedge clkin) begin
        logic take_rd;
        logic take_wr;
        logic push_rd;
        logic push_wr;
        if (rst) begin
            rd_m.delete();
            wr_m.delete();
            gnt_m       = 1'b0;
            exp_valid   = 1'b0;
            exp_is_read = 1'b0;
            exp_addr    = '0;
            model_live  = 1'b0;
        end else begin
            take_rd = 1'b0;
            take_wr = 1'b0;
            if (gnt_m) begin                            // grant seen one edge ago
                if (rd_m.size() > 0) begin
                    take_rd = !write_pending(rd_m[0]);
                end
                take_wr = !take_rd && (wr_m.size() > 0);
            end
            push_rd = valid_in && is_read && (rd_m.size() < CAP);   // full drops it
            push_wr = valid_in && !is_read && (wr_m.size() < CAP);
            exp_valid = take_rd || take_wr;
            if (take_rd) begin
                exp_addr    = rd_m.pop_front();
                exp_is_read = 1'b1;
            end else if (take_wr) begin
                exp_addr    = wr_m.pop_front();
                exp_is_read = 1'b0;
            end
            if (push_rd) rd_m.push_back(in_addr);
            if (push_wr) wr_m.push_back(in_addr);
            gnt_m      = bus_gnt;
            model_live = 1'b1;
        end
    end

    // per-cycle compare, outputs settled since the rising edge
    always @(negedge clkin) begin
        if (model_live) begin
            if (valid_out !== exp_valid) begin
                $display("Mismatch at %0t: valid_out %b, model expects %b",
                         $time, valid_out, exp_valid);
                model_errors++;
            end else if (exp_valid && {out_is_read, out_addr} !== {exp_is_read, exp_addr}) begin
                $display("Mismatch at %0t: issued %s %h, model expects %s %h", $time,
                         out_is_read ? "read" : "write", out_addr,
                         exp_is_read ? "read" : "write", exp_addr);
                model_errors++;
            end
            if (read_full !== (rd_m.size() == CAP) || write_full !== (wr_m.size() == CAP)) begin
                $display("Mismatch at %0t: full flags rd %b wr %b, model holds %0d/%0d",
                         $time, read_full, write_full, rd_m.size(), wr_m.size());
                model_errors++;
            end
            if (rd_m.size() > 0 && read_head_addr !== rd_m[0]) begin
                $display("Mismatch at %0t: read_head_addr %h, model head %h",
                         $time, read_head_addr, rd_m[0]);
                model_errors++;
            end
        end
    end

    task automatic send(input logic rd, input logic [memq_pkg::ADDR_W-1:0] addr);
        @(negedge clkin);
        valid_in = 1'b1;
        is_read  = rd;
        in_addr  = addr;
    endtask

    // also ends any request strobe
    task automatic set_gnt(input logic g);
        @(negedge clkin);
        valid_in = 1'b0;
        bus_gnt  = g;
    endtask

    // collect n issues; with hold_check the read head must stay put until it issues
    task automatic wait_issues(input int n, input logic hold_check,
                               input logic [memq_pkg::ADDR_W-1:0] hold_addr);
        int   waited;
        logic hold_done;
        waited    = 0;
        hold_done = !hold_check;
        while (got_q.size() < n && waited < WAIT_LIMIT) begin
            @(negedge clkin);
            waited++;
            if (valid_out) got_q.push_back({out_is_read, out_addr});
            if (!hold_done) begin
                if (valid_out && out_is_read && out_addr == hold_addr) begin
                    hold_done = 1'b1;
                end else if (read_head_addr !== hold_addr) begin
                    $display("Mismatch at %0t: read_head_addr %h, expected held %h",
                             $time, read_head_addr, hold_addr);
                    errors++;
                end
            end
        end
        if (got_q.size() < n) begin
            $display("timeout: only %0d of %0d issues seen", got_q.size(), n);
            errors++;
        end
    endtask

    task automatic expect_issue(input int idx, input logic rd,
                                input logic [memq_pkg::ADDR_W-1:0] addr);
        if (idx >= got_q.size()) begin
            $display("issue %0d was never seen", idx);
            errors++;
        end else if (got_q[idx] !== {rd, addr}) begin
            $display("Mismatch at %0t: issue %0d was %s %h, expected %s %h", $time, idx,
                     got_q[idx][memq_pkg::ADDR_W] ? "read" : "write",
                     got_q[idx][memq_pkg::ADDR_W-1:0], rd ? "read" : "write", addr);
            errors++;
        end
    endtask

    // fixed window: no issue, no full flag, read head unchanged
    task automatic check_quiet(input int cycles);
        logic [memq_pkg::ADDR_W-1:0] head;
        head = read_head_addr;
        repeat (cycles) begin
            @(negedge clkin);
            if (valid_out || read_full || write_full || read_head_addr !== head) begin
                $display("Mismatch at %0t: quiet window saw valid %b full %b/%b head %h->%h",
                         $time, valid_out, read_full, write_full, head, read_head_addr);
                errors++;
            end
        end
    endtask

    task automatic drain();
        int waited;
        set_gnt(1'b1);
        waited = 0;
        while ((rd_m.size() > 0 || wr_m.size() > 0 || exp_valid) && waited < WAIT_LIMIT) begin
            @(negedge clkin);
            waited++;
        end
        if (rd_m.size() > 0 || wr_m.size() > 0) begin
            $display("timeout: queues did not drain, %0d reads and %0d writes left",
                     rd_m.size(), wr_m.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        int n;
        n = error_total() - start;
        tests_run++;
        if (n == 0) $display("%s: ok", name);
        else        $display("%s: %0d errors", name, n);
    endtask

    task automatic test_idle_after_reset();
        int start;
        start = error_total();
        set_gnt(1'b1);
        check_quiet(10);
        end_test("idle after reset", start);
    endtask

    task automatic test_read_priority();
        int start;
        start = error_total();
        got_q.delete();
        set_gnt(1'b0);
        send(1'b0, 8'h10);
        send(1'b0, 8'h20);
        send(1'b1, 8'h30);
        send(1'b1, 8'h40);
        set_gnt(1'b1);
        wait_issues(4, 1'b0, '0);
        expect_issue(0, 1'b1, 8'h30);   // reads first, in arrival order
        expect_issue(1, 1'b1, 8'h40);
        expect_issue(2, 1'b0, 8'h10);
        expect_issue(3, 1'b0, 8'h20);
        drain();
        end_test("read priority", start);
    endtask

    task automatic test_raw_hazard();
        int start;
        start = error_total();
        got_q.delete();
        set_gnt(1'b0);
        send(1'b0, 8'h55);
        send(1'b1, 8'h55);
        send(1'b1, 8'h66);
        set_gnt(1'b1);
        wait_issues(3, 1'b1, 8'h55);    // head holds 55 until that read goes out
        expect_issue(0, 1'b0, 8'h55);
        expect_issue(1, 1'b1, 8'h55);
        expect_issue(2, 1'b1, 8'h66);
        drain();
        end_test("read after write hazard", start);
    endtask

    task automatic test_full_drop();
        int start;
        start = error_total();
        got_q.delete();
        set_gnt(1'b0);
        for (int i = 1; i <= 4; i++) begin
            @(negedge clkin);
            if (read_full !== (i == 4)) begin     // full only once three are held
                $display("Mismatch at %0t: read_full %b before read %0d", $time, read_full, i);
                errors++;
            end
            valid_in = 1'b1;
            is_read  = 1'b1;
            in_addr  = 8'(i);
        end
        set_gnt(1'b0);
        if (read_full !== 1'b1) begin
            $display("Mismatch at %0t: read_full low after four pushes", $time);
            errors++;
        end
        set_gnt(1'b1);
        wait_issues(3, 1'b0, '0);
        check_quiet(6);                 // the dropped fourth never shows up
        expect_issue(0, 1'b1, 8'h01);
        expect_issue(1, 1'b1, 8'h02);
        expect_issue(2, 1'b1, 8'h03);
        end_test("full queue drop", start);
    endtask

    task automatic test_back_pressure();
        int start;
        start = error_total();
        got_q.delete();
        set_gnt(1'b0);
        send(1'b1, 8'h21);
        send(1'b0, 8'h22);
        send(1'b1, 8'h23);
        set_gnt(1'b0);
        if (read_head_addr !== 8'h21) begin
            $display("Mismatch at %0t: read_head_addr %h, expected 21", $time, read_head_addr);
            errors++;
        end
        check_quiet(8);
        set_gnt(1'b1);
        wait_issues(3, 1'b0, '0);
        expect_issue(0, 1'b1, 8'h21);
        expect_issue(1, 1'b1, 8'h23);
        expect_issue(2, 1'b0, 8'h22);
        drain();
        end_test("back pressure", start);
    endtask

    task automatic test_random_mix();
        int start;
        int r;
        start = error_total();
        seed  = SEED_INIT;
        repeat (200) begin
            @(negedge clkin);
            r        = $random(seed);
            valid_in = r[0];
            is_read  = r[1];
            in_addr  = {6'b010000, r[3:2]};   // four addresses, plenty of hazards
            bus_gnt  = r[4] | r[5];           // grant about three cycles in four
        end
        drain();
        end_test("random mix", start);
    endtask

    initial begin
        rst      = 1'b1;
        valid_in = 1'b0;
        is_read  = 1'b0;
        in_addr  = '0;
        bus_gnt  = 1'b0;
        repeat (4) @(negedge clkin);
        rst = 1'b0;

        test_idle_after_reset();
        test_read_priority();
        test_raw_hazard();
        test_full_drop();
        test_back_pressure();
        test_random_mix();

        $display("tests run %0d, errors %0d (bench %0d, model %0d, assertions %0d)",
                 tests_run, error_total(), errors, model_errors, u_dut.u_asserts.failures);
        if (error_total() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== memq.f ====
logic/memq_pkg.sv
logic/req_queue_if.sv
logic/req_fifo.sv
logic/raw_hazard_check.sv
logic/issue_arbiter.sv
logic/memq_top.sv
bench/memq_asserts.sv
bench/memq_tb.sv

// ==== Makefile ====
# Verilator build and run of the memq testbench

SIM := obj_dir/Vmemq_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): memq.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --timing --assert -j 0 --top-module memq_tb -f memq.f

# output stays on the terminal, status comes from the search
run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
